// File: source/apb_subsystem_pkg.sv
`default_nettype none

package apb_subsystem_pkg;

	// Bus widths
	localparam int addr_width = 12;
	localparam int data_width = 32;

	// Region field inside paddr
	localparam int region_msb = 11;
	localparam int region_lsb = 8;
	localparam int region_width = region_msb - region_lsb + 1;

	// Address map, one region per completer
	// Anything not listed here is unmapped and answers with an error
	localparam logic[region_width-1:0] region_status = 0;
	localparam logic[region_width-1:0] region_control = 1;
	localparam logic[region_width-1:0] region_counter = 2;

	// Event counter
	localparam int count_width = 16;

	// Control register that carries the count enable in bit 0
	localparam int control_enable_index = 0;

	// Arbiter FSM encoding
	localparam logic[1:0] arb_idle = 2'd0;
	localparam logic[1:0] arb_setup = 2'd1;
	localparam logic[1:0] arb_access = 2'd2;
	localparam logic[1:0] arb_finish = 2'd3;

	// Status word, seen either as one word or as fields
	typedef union packed {
		logic[data_width-1:0] raw;
		struct packed {
			// Sticky, set when the count wraps
			logic overflow;
			// Mirrors the count enable from the control bank
			logic enabled;
			logic[data_width-count_width-3:0] reserved;
			logic[count_width-1:0] count;
		} fields;
	} status_word_t;

endpackage

`default_nettype wire

// File: source/apb_requester_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module apb_requester_arbiter(
	input wire pclk,
	input wire reset,

	// Requester a
	input wire req_a,
	input wire write_a,
	input wire[apb_subsystem_pkg::addr_width-1:0] addr_a,
	input wire[apb_subsystem_pkg::data_width-1:0] wdata_a,
	output logic done_a,
	output logic[apb_subsystem_pkg::data_width-1:0] rdata_a,
	output logic err_a,

	// Requester b
	input wire req_b,
	input wire write_b,
	input wire[apb_subsystem_pkg::addr_width-1:0] addr_b,
	input wire[apb_subsystem_pkg::data_width-1:0] wdata_b,
	output logic done_b,
	output logic[apb_subsystem_pkg::data_width-1:0] rdata_b,
	output logic err_b,

	// APB requester side
	output logic psel,
	output logic penable,
	output logic pwrite,
	output logic[apb_subsystem_pkg::addr_width-1:0] paddr,
	output logic[apb_subsystem_pkg::data_width-1:0] pwdata,
	input wire[apb_subsystem_pkg::data_width-1:0] prdata,
	input wire pready,
	input wire pslverr
);

	logic[1:0] state;

	// Owner of the current transfer, and afterwards the last winner
	logic winner_b;

	// Port picked in this idle cycle
	logic grant_b;

	// Round robin only matters when both ports ask at once
	always_comb begin
		if(req_a && req_b)
			grant_b = !winner_b;
		else
			grant_b = req_b;
	end

	// Bus phases straight from the state
	assign psel = (state == apb_subsystem_pkg::arb_setup) ||
		(state == apb_subsystem_pkg::arb_access);
	assign penable = (state == apb_subsystem_pkg::arb_access);

	always_ff @(posedge pclk) begin

		// done is a single cycle pulse
		done_a <= 1'b0;
		done_b <= 1'b0;

		case(state)

			// Sample requests, latch the winner's transfer
			apb_subsystem_pkg::arb_idle: begin
				if(req_a || req_b) begin
					state <= apb_subsystem_pkg::arb_setup;
					winner_b <= grant_b;
					pwrite <= grant_b ? write_b : write_a;
					paddr <= grant_b ? addr_b : addr_a;
					pwdata <= grant_b ? wdata_b : wdata_a;
				end
			end

			apb_subsystem_pkg::arb_setup:
				state <= apb_subsystem_pkg::arb_access;

			// Hold access until the completer is ready
			apb_subsystem_pkg::arb_access: begin
				if(pready) begin
					state <= apb_subsystem_pkg::arb_finish;

					// Response goes to the owner only
					if(winner_b) begin
						done_b <= 1'b1;
						rdata_b <= prdata;
						err_b <= pslverr;
					end
					else begin
						done_a <= 1'b1;
						rdata_a <= prdata;
						err_a <= pslverr;
					end
				end
			end

			// done is out, requester drops req now
			// One idle cycle follows before the next sample
			default:
				state <= apb_subsystem_pkg::arb_idle;

		endcase

		// Control state only, bus payload keeps its value
		if(reset) begin
			state <= apb_subsystem_pkg::arb_idle;
			winner_b <= 1'b1;
			done_a <= 1'b0;
			done_b <= 1'b0;
			err_a <= 1'b0;
			err_b <= 1'b0;
		end
	end

	// Access never happens without select
	assert property(@(posedge pclk) disable iff(reset) penable |-> psel);

	// Address held from setup through the end of access
	assert property(@(posedge pclk) disable iff(reset) penable |-> $stable(paddr));

	// Only one requester is answered per transfer
	assert property(@(posedge pclk) disable iff(reset) !(done_a && done_b));

endmodule

`default_nettype wire

// File: source/apb_address_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module apb_address_decoder(
	input wire psel,
	input wire penable,
	input wire[apb_subsystem_pkg::addr_width-1:0] paddr,

	// Per completer selects
	output logic status_psel,
	output logic control_psel,
	output logic counter_psel,

	// Per completer responses
	input wire[apb_subsystem_pkg::data_width-1:0] status_prdata,
	input wire status_pready,
	input wire status_pslverr,
	input wire[apb_subsystem_pkg::data_width-1:0] control_prdata,
	input wire control_pready,
	input wire control_pslverr,
	input wire[apb_subsystem_pkg::data_width-1:0] counter_prdata,
	input wire counter_pready,
	input wire counter_pslverr,

	// Muxed response back to the arbiter
	output logic[apb_subsystem_pkg::data_width-1:0] prdata,
	output logic pready,
	output logic pslverr
);

	logic[apb_subsystem_pkg::region_width-1:0] region;
	assign region = paddr[apb_subsystem_pkg::region_msb:apb_subsystem_pkg::region_lsb];

	always_comb begin
		status_psel = 1'b0;
		control_psel = 1'b0;
		counter_psel = 1'b0;
		prdata = '0;
		pready = 1'b0;
		pslverr = 1'b0;

		case(region)
			apb_subsystem_pkg::region_status: begin
				status_psel = psel;
				prdata = status_prdata;
				pready = status_pready;
				pslverr = status_pslverr;
			end
			apb_subsystem_pkg::region_control: begin
				control_psel = psel;
				prdata = control_prdata;
				pready = control_pready;
				pslverr = control_pslverr;
			end
			apb_subsystem_pkg::region_counter: begin
				counter_psel = psel;
				prdata = counter_prdata;
				pready = counter_pready;
				pslverr = counter_pslverr;
			end

			// Unmapped, answered here with zero data
			default: begin
				pready = psel && penable;
				pslverr = psel && penable;
			end
		endcase
	end

	// No two completers see the same transfer
	always_comb
		assert($onehot0({status_psel, control_psel, counter_psel}));

endmodule

`default_nettype wire

// File: source/apb_status_register.sv
`timescale 1ns/10ps
`default_nettype none

module apb_status_register(
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire apb_subsystem_pkg::status_word_t status,

	output logic[apb_subsystem_pkg::data_width-1:0] prdata,
	output logic pready,
	output logic pslverr
);

	logic access;
	assign access = psel && penable;

	// No wait states
	assign pready = access;

	always_comb begin
		prdata = '0;
		pslverr = 1'b0;

		if(access) begin
			// Read only, any write is refused
			if(pwrite)
				pslverr = 1'b1;
			// Same word at every offset in the region
			else
				prdata = status.raw;
		end
	end

endmodule

`default_nettype wire

// File: source/apb_control_registers.sv
`timescale 1ns/10ps
`default_nettype none

module apb_control_registers(
	input wire pclk,
	input wire reset,

	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire[apb_subsystem_pkg::addr_width-1:0] paddr,
	input wire[apb_subsystem_pkg::data_width-1:0] pwdata,

	output logic[apb_subsystem_pkg::data_width-1:0] prdata,
	output logic pready,
	output logic pslverr,

	output logic count_enable
);

	// Register 0 is the enable word, 1 to 3 are scratch
	logic[apb_subsystem_pkg::data_width-1:0] regs[4];

	// Word select, byte offset bits ignored
	logic[1:0] index;
	assign index = paddr[3:2];

	logic access;
	assign access = psel && penable;

	// Always ready, never an error
	assign pready = access;
	assign pslverr = 1'b0;

	// Readback only during a read access
	always_comb begin
		if(access && !pwrite)
			prdata = regs[index];
		else
			prdata = '0;
	end

	always_ff @(posedge pclk) begin

		// Write lands at the edge that ends access
		if(access && pwrite)
			regs[index] <= pwdata;

		// Only the enable word is control state
		if(reset)
			regs[apb_subsystem_pkg::control_enable_index] <= '0;
	end

	assign count_enable = regs[apb_subsystem_pkg::control_enable_index][0];

endmodule

`default_nettype wire

// File: source/apb_event_counter.sv
`timescale 1ns/10ps
`default_nettype none

module apb_event_counter(
	input wire pclk,
	input wire reset,

	input wire psel,
	input wire penable,
	input wire pwrite,

	output logic[apb_subsystem_pkg::data_width-1:0] prdata,
	output logic pready,
	output logic pslverr,

	// Counted once per cycle while high
	input wire event_pulse,
	input wire count_enable,

	output apb_subsystem_pkg::status_word_t status
);

	logic[apb_subsystem_pkg::count_width-1:0] count;
	logic overflow;

	logic access;
	assign access = psel && penable;

	// Any write clears
	logic clear;
	assign clear = access && pwrite;

	always_ff @(posedge pclk) begin
		if(reset || clear) begin
			count <= '0;
			overflow <= 1'b0;
		end

		else if(count_enable && event_pulse) begin
			count <= count + 1'b1;

			// Wrap from all ones sets the sticky flag
			if(&count)
				overflow <= 1'b1;
		end
	end

	// Status word assembled field by field
	always_comb begin
		status.fields.overflow = overflow;
		status.fields.enabled = count_enable;
		status.fields.reserved = '0;
		status.fields.count = count;
	end

	// No wait states
	// Reads return the status word at any offset
	assign pready = access;
	assign pslverr = 1'b0;
	assign prdata = (access && !pwrite) ? status.raw : '0;

endmodule

`default_nettype wire

// File: source/apb_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module apb_subsystem(
	input wire pclk,
	input wire reset,

	// Requester a
	input wire req_a,
	input wire write_a,
	input wire[apb_subsystem_pkg::addr_width-1:0] addr_a,
	input wire[apb_subsystem_pkg::data_width-1:0] wdata_a,
	output logic done_a,
	output logic[apb_subsystem_pkg::data_width-1:0] rdata_a,
	output logic err_a,

	// Requester b
	input wire req_b,
	input wire write_b,
	input wire[apb_subsystem_pkg::addr_width-1:0] addr_b,
	input wire[apb_subsystem_pkg::data_width-1:0] wdata_b,
	output logic done_b,
	output logic[apb_subsystem_pkg::data_width-1:0] rdata_b,
	output logic err_b,

	input wire event_pulse
);

	// Shared APB bus
	logic psel;
	logic penable;
	logic pwrite;
	logic[apb_subsystem_pkg::addr_width-1:0] paddr;
	logic[apb_subsystem_pkg::data_width-1:0] pwdata;
	logic[apb_subsystem_pkg::data_width-1:0] prdata;
	logic pready;
	logic pslverr;

	// Completer selects and responses
	logic status_psel;
	logic control_psel;
	logic counter_psel;
	logic[apb_subsystem_pkg::data_width-1:0] status_prdata;
	logic[apb_subsystem_pkg::data_width-1:0] control_prdata;
	logic[apb_subsystem_pkg::data_width-1:0] counter_prdata;
	logic status_pready;
	logic control_pready;
	logic counter_pready;
	logic status_pslverr;
	logic control_pslverr;
	logic counter_pslverr;

	// Side band between completers
	logic count_enable;
	apb_subsystem_pkg::status_word_t status;

	apb_requester_arbiter i_arbiter(
		.pclk(pclk),
		.reset(reset),
		.req_a(req_a),
		.write_a(write_a),
		.addr_a(addr_a),
		.wdata_a(wdata_a),
		.done_a(done_a),
		.rdata_a(rdata_a),
		.err_a(err_a),
		.req_b(req_b),
		.write_b(write_b),
		.addr_b(addr_b),
		.wdata_b(wdata_b),
		.done_b(done_b),
		.rdata_b(rdata_b),
		.err_b(err_b),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	apb_address_decoder i_decoder(
		.psel(psel),
		.penable(penable),
		.paddr(paddr),
		.status_psel(status_psel),
		.control_psel(control_psel),
		.counter_psel(counter_psel),
		.status_prdata(status_prdata),
		.status_pready(status_pready),
		.status_pslverr(status_pslverr),
		.control_prdata(control_prdata),
		.control_pready(control_pready),
		.control_pslverr(control_pslverr),
		.counter_prdata(counter_prdata),
		.counter_pready(counter_pready),
		.counter_pslverr(counter_pslverr),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	apb_status_register i_status(
		.psel(status_psel),
		.penable(penable),
		.pwrite(pwrite),
		.status(status),
		.prdata(status_prdata),
		.pready(status_pready),
		.pslverr(status_pslverr)
	);

	apb_control_registers i_control(
		.pclk(pclk),
		.reset(reset),
		.psel(control_psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(control_prdata),
		.pready(control_pready),
		.pslverr(control_pslverr),
		.count_enable(count_enable)
	);

	apb_event_counter i_counter(
		.pclk(pclk),
		.reset(reset),
		.psel(counter_psel),
		.penable(penable),
		.pwrite(pwrite),
		.prdata(counter_prdata),
		.pready(counter_pready),
		.pslverr(counter_pslverr),
		.event_pulse(event_pulse),
		.count_enable(count_enable),
		.status(status)
	);

endmodule

`default_nettype wire

// File: testbench/apb_subsystem_tb.sv
`timescale 1ns/10ps
`default_nettype none

module apb_subsystem_tb;

	// Clock and run length
	localparam int clock_period = 100;
	localparam int reset_cycles = 3;
	localparam int transfer_limit = 16;
	localparam int overflow_events = 65536;
	localparam int event_burst = 64;
	localparam int transfer_budget = 200;
	localparam int transfer_cycles = 10;
	localparam int watchdog_cycles = reset_cycles + overflow_events + 4 * event_burst +
		transfer_budget * transfer_cycles + 1000;

	// Request is sampled one edge after it is driven
	// Done comes 3 cycles after that sample
	localparam int done_latency = 4;
	// Loser waits out finish and one idle cycle before its own transfer
	localparam int loser_gap = 4;

	logic pclk = 1'b0;
	logic reset;
	logic req_a;
	logic write_a;
	logic[11:0] addr_a;
	logic[31:0] wdata_a;
	logic done_a;
	logic[31:0] rdata_a;
	logic err_a;
	logic req_b;
	logic write_b;
	logic[11:0] addr_b;
	logic[31:0] wdata_b;
	logic done_b;
	logic[31:0] rdata_b;
	logic err_b;
	logic event_pulse;

	// Model state
	logic[31:0] ctrl_model[4];
	logic[15:0] count_model;
	logic overflow_model;
	// Port that owned the most recent transfer
	bit last_winner_b;

	// Expected response per port
	// Set when the request goes out
	logic[31:0] exp_rdata_a;
	logic[31:0] exp_rdata_b;
	logic exp_err_a;
	logic exp_err_b;
	bit pending_a;
	bit pending_b;

	int cycle_count = 0;

	apb_subsystem i_apb_subsystem(
		.pclk(pclk),
		.reset(reset),
		.req_a(req_a),
		.write_a(write_a),
		.addr_a(addr_a),
		.wdata_a(wdata_a),
		.done_a(done_a),
		.rdata_a(rdata_a),
		.err_a(err_a),
		.req_b(req_b),
		.write_b(write_b),
		.addr_b(addr_b),
		.wdata_b(wdata_b),
		.done_b(done_b),
		.rdata_b(rdata_b),
		.err_b(err_b),
		.event_pulse(event_pulse)
	);

	always #(clock_period / 2) pclk = !pclk;

	always @(posedge pclk)
		cycle_count <= cycle_count + 1;

	task automatic abort_run;
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic[31:0] expected,
			input logic[31:0] actual);
		if(actual !== expected) begin
			$display("error at %0t: %s expected %h actual %h", $time, name, expected, actual);
			abort_run();
		end
	endtask

	// Returns {err, rdata} for a transfer against the current model state
	function automatic logic[32:0] expected_response(input logic[11:0] addr, input bit write);
		logic[3:0] region;
		logic[31:0] status_word;
		region = addr[11:8];
		// Overflow, enabled, 14 reserved zeros, count
		status_word = {overflow_model, ctrl_model[0][0], 14'd0, count_model};
		case(region)
			4'd0: expected_response = write ? {1'b1, 32'd0} : {1'b0, status_word};
			4'd1: expected_response = write ? 33'd0 : {1'b0, ctrl_model[addr[3:2]]};
			4'd2: expected_response = write ? 33'd0 : {1'b0, status_word};
			default: expected_response = {1'b1, 32'd0};
		endcase
	endfunction

	// Model side effect of a completed write
	task automatic apply_write(input logic[11:0] addr, input logic[31:0] wdata);
		case(addr[11:8])
			4'd1: ctrl_model[addr[3:2]] = wdata;
			4'd2: begin
				count_model = 16'd0;
				overflow_model = 1'b0;
			end
			default: begin
			end
		endcase
	endtask

	// One transfer on one port held until done
	task automatic bus_transfer(input bit port_b, input bit write, input logic[11:0] addr,
			input logic[31:0] wdata, output int issue_cycle, output int done_cycle);
		logic[32:0] expected;
		int waited;
		bit seen;
		expected = expected_response(addr, write);
		@(posedge pclk);
		issue_cycle = cycle_count;
		if(port_b) begin
			{exp_err_b, exp_rdata_b} = expected;
			pending_b = 1'b1;
			req_b <= 1'b1;
			write_b <= write;
			addr_b <= addr;
			wdata_b <= wdata;
		end
		else begin
			{exp_err_a, exp_rdata_a} = expected;
			pending_a = 1'b1;
			req_a <= 1'b1;
			write_a <= write;
			addr_a <= addr;
			wdata_a <= wdata;
		end
		waited = 0;
		seen = 1'b0;
		while(!seen && waited < transfer_limit) begin
			@(posedge pclk);
			waited++;
			seen = port_b ? done_b : done_a;
		end
		if(!seen) begin
			$display("port %s got no done within %0d cycles of its request",
				port_b ? "b" : "a", transfer_limit);
			abort_run();
		end
		else begin
			done_cycle = cycle_count;
			// Drop req in the cycle after done
			if(port_b) begin
				req_b <= 1'b0;
				pending_b = 1'b0;
			end
			else begin
				req_a <= 1'b0;
				pending_a = 1'b0;
			end
			last_winner_b = port_b;
			if(write)
				apply_write(addr, wdata);
		end
	endtask

	task automatic single_access(input bit port_b, input bit write, input logic[11:0] addr,
			input logic[31:0] wdata);
		int issue_cycle;
		int done_cycle;
		bus_transfer(port_b, write, addr, wdata, issue_cycle, done_cycle);
	endtask

	// Both ports request in the same cycle
	// Winner is the port that did not own the last one
	task automatic contention_round(input bit write, input logic[11:0] a_addr,
			input logic[31:0] a_data, input logic[11:0] b_addr, input logic[31:0] b_data);
		int issue_a;
		int issue_b;
		int finish_a;
		int finish_b;
		bit expect_b;
		expect_b = !last_winner_b;
		fork
			bus_transfer(1'b0, write, a_addr, a_data, issue_a, finish_a);
			bus_transfer(1'b1, write, b_addr, b_data, issue_b, finish_b);
		join
		if(expect_b) begin
			check_value("done_b latency", done_latency, finish_b - issue_b);
			check_value("done_a after done_b", loser_gap, finish_a - finish_b);
		end
		else begin
			check_value("done_a latency", done_latency, finish_a - issue_a);
			check_value("done_b after done_a", loser_gap, finish_b - finish_a);
		end
	endtask

	// Event pulses at most one per cycle
	// Model follows the enable bit
	task automatic drive_events(input int cycles, input bit random_pattern);
		int i;
		logic pulse;
		for(i = 0; i < cycles; i++) begin
			@(posedge pclk);
			pulse = random_pattern ? 1'($urandom()) : 1'b1;
			event_pulse <= pulse;
			if(pulse && ctrl_model[0][0]) begin
				if(&count_model)
					overflow_model = 1'b1;
				count_model = count_model + 16'd1;
			end
		end
		@(posedge pclk);
		event_pulse <= 1'b0;
	endtask

	// Responses checked mid cycle where done, rdata and err are settled
	always @(negedge pclk) begin
		if(!reset) begin
			if(done_a && !pending_a) begin
				$display("done_a pulsed at %0t with no transfer open on port a", $time);
				abort_run();
			end
			else if(done_a) begin
				check_value("rdata_a", exp_rdata_a, rdata_a);
				check_value("err_a", 32'(exp_err_a), 32'(err_a));
			end
			if(done_b && !pending_b) begin
				$display("done_b pulsed at %0t with no transfer open on port b", $time);
				abort_run();
			end
			else if(done_b) begin
				check_value("rdata_b", exp_rdata_b, rdata_b);
				check_value("err_b", 32'(exp_err_b), 32'(err_b));
			end
		end
	end

	// Watchdog
	initial begin
		#(watchdog_cycles * clock_period);
		$display("run did not finish within %0d cycles", watchdog_cycles);
		abort_run();
	end

	initial begin
		int i;
		int r;
		logic[31:0] data;
		logic[1:0] index;
		logic[11:0] addr;
		void'($urandom(32'h307e));
		reset <= 1'b1;
		req_a <= 1'b0;
		write_a <= 1'b0;
		addr_a <= '0;
		wdata_a <= '0;
		req_b <= 1'b0;
		write_b <= 1'b0;
		addr_b <= '0;
		wdata_b <= '0;
		event_pulse <= 1'b0;
		for(i = 0; i < 4; i++)
			ctrl_model[i] = 32'd0;
		count_model = 16'd0;
		overflow_model = 1'b0;
		// Arbiter leaves reset as if b won last
		last_winner_b = 1'b1;
		repeat(reset_cycles) @(posedge pclk);
		reset <= 1'b0;

		// Contention right after reset with a first
		contention_round(1'b1, 12'h104, $urandom(), 12'h108, $urandom());
		contention_round(1'b0, 12'h108, 32'd0, 12'h104, 32'd0);

		// Status region reads and a refused write
		for(i = 0; i < 8; i++)
			single_access(1'($urandom()), 1'b0, {4'd0, 8'($urandom())}, 32'd0);
		single_access(1'b0, 1'b1, {4'd0, 8'($urandom())}, $urandom());
		single_access(1'b1, 1'b0, {4'd0, 8'($urandom())}, 32'd0);

		// Control bank write and readback with random low offset bits
		for(i = 0; i < 16; i++) begin
			index = (i < 4) ? 2'(i) : 2'($urandom());
			data = $urandom();
			addr = {4'd1, 4'($urandom()), index, 2'($urandom())};
			single_access(1'($urandom()), 1'b1, addr, data);
			single_access(1'($urandom()), 1'b0, addr, 32'd0);
		end
		single_access(1'b0, 1'b0, {4'd0, 8'($urandom())}, 32'd0);

		// Counting enabled
		data = $urandom();
		single_access(1'b1, 1'b1, {4'd1, 4'($urandom()), 4'd0}, data | 32'd1);
		drive_events(event_burst, 1'b1);
		single_access(1'b0, 1'b0, {4'd2, 8'($urandom())}, 32'd0);
		// Count holds while counting is disabled
		single_access(1'b0, 1'b1, {4'd1, 4'($urandom()), 4'd0}, data & ~32'd1);
		drive_events(event_burst, 1'b1);
		single_access(1'b1, 1'b0, {4'd2, 8'($urandom())}, 32'd0);
		single_access(1'b1, 1'b0, {4'd0, 8'($urandom())}, 32'd0);
		// Refused status write leaves a nonzero count alone
		single_access(1'b0, 1'b1, {4'd0, 8'($urandom())}, $urandom());
		single_access(1'b1, 1'b0, {4'd0, 8'($urandom())}, 32'd0);
		// Clear through the counter region
		single_access(1'b0, 1'b1, {4'd2, 8'($urandom())}, $urandom());
		single_access(1'b1, 1'b0, {4'd2, 8'($urandom())}, 32'd0);

		// Full wrap of the count
		single_access(1'b0, 1'b1, 12'h100, 32'd1);
		drive_events(overflow_events, 1'b0);
		single_access(1'b1, 1'b0, {4'd2, 8'($urandom())}, 32'd0);
		// Overflow is sticky
		drive_events(event_burst, 1'b1);
		single_access(1'b0, 1'b0, {4'd0, 8'($urandom())}, 32'd0);
		single_access(1'b1, 1'b1, {4'd2, 8'($urandom())}, $urandom());
		single_access(1'b0, 1'b0, {4'd2, 8'($urandom())}, 32'd0);

		// Nonzero count so a stray clear from an unmapped write shows up
		drive_events(event_burst, 1'b1);

		// Unmapped regions
		for(r = 3; r < 16; r++) begin
			single_access(1'($urandom()), 1'b1, {4'(r), 8'($urandom())}, $urandom());
			single_access(1'($urandom()), 1'b0, {4'(r), 8'($urandom())}, 32'd0);
		end
		for(i = 0; i < 4; i++)
			single_access(1'($urandom()), 1'b0, {4'd1, 4'd0, 2'(i), 2'd0}, 32'd0);
		single_access(1'b1, 1'b0, {4'd0, 8'($urandom())}, 32'd0);

		// b wins next because a owned the last transfer
		single_access(1'b0, 1'b0, {4'd0, 8'($urandom())}, 32'd0);
		contention_round(1'b0, 12'h10c, 32'd0, 12'h200, 32'd0);
		contention_round(1'b1, 12'h10c, $urandom(), 12'h204, $urandom());
		single_access(1'b1, 1'b0, 12'h10c, 32'd0);

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
source/apb_subsystem_pkg.sv
source/apb_requester_arbiter.sv
source/apb_address_decoder.sv
source/apb_status_register.sv
source/apb_control_registers.sv
source/apb_event_counter.sv
source/apb_subsystem.sv
testbench/apb_subsystem_tb.sv

// File: Makefile
TOP = apb_subsystem_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps --top-module $(TOP) -f sim.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
